//--- source/tpl_dac_params.svh
/*
 * JESD204 transport-layer DAC geometry
 * link, sample and DMA widths, padding placement and register map
 */

`ifndef TPL_DAC_PARAMS_SVH
`define TPL_DAC_PARAMS_SVH

`define NUM_CHANNELS      2
`define NUM_LANES         2
`define OCTETS_PER_BEAT   4
`define SAMPLES_PER_BEAT  2
`define SAMPLE_BITS       12
`define SLOT_BITS         16
`define DMA_BITS          16
// 1: sample in the low DMA bits, padding in the MSBs
`define PAD_TO_MSB        1
`define LINK_BITS         64
`define CORE_ID           32'h7D0A_C001

`define REG_ID            8'h00
`define REG_CTRL          8'h01
`define REG_STATUS        8'h02
`define REG_CH_SEL        8'h10
`define REG_CH_PAT        8'h14
`define REG_CH_STEP       8'h18

`endif

//--- source/tpl_dac_pkg.sv
/*
 * Transport-layer DAC types
 * sample, word and slot widths, source select and per-channel records
 */

`include "tpl_dac_params.svh"

package tpl_dac_pkg;

  // converter sample, N bits
  typedef logic [`SAMPLE_BITS-1:0] sample_t;

  // one word as delivered by the DMA
  typedef logic [`DMA_BITS-1:0] dma_word_t;

  // one link slot, NP bits
  typedef logic [`SLOT_BITS-1:0] slot_t;

  typedef enum logic [1:0] {
    SRC_DMA     = 2'd0,
    SRC_PATTERN = 2'd1,
    SRC_RAMP    = 2'd2,
    SRC_ZERO    = 2'd3
  } src_sel_e;

  typedef struct packed {
    src_sel_e src_sel;
    sample_t  pattern;
    sample_t  ramp_step;
  } chan_cfg_t;

  // element 0 is the earlier sample of the beat
  typedef sample_t [`SAMPLES_PER_BEAT-1:0] chan_beat_t;

endpackage

//--- source/dma_sample_unpack.sv
/*
 * DMA sample unpack
 * registers the DMA words of each beat, drops the padding bits
 * and forwards underflow as a single-cycle event
 */

`include "tpl_dac_params.svh"

module dma_sample_unpack (
  input  logic                                                   link_clk,
  input  logic                                                   rst,
  input  logic                                                   link_ready,
  input  logic [`NUM_CHANNELS*`SAMPLES_PER_BEAT*`DMA_BITS-1:0]   dac_ddata,
  input  logic                                                   dac_dunf,
  output tpl_dac_pkg::chan_beat_t [`NUM_CHANNELS-1:0]            dma_beat,
  output logic                                                   dunf_flag
);

  import tpl_dac_pkg::*;

  chan_beat_t [`NUM_CHANNELS-1:0] beat_in;

  // word c*SPB+s carries sample s of channel c
  always_comb begin
    dma_word_t word;
    for (int c = 0; c < `NUM_CHANNELS; c++) begin
      for (int s = 0; s < `SAMPLES_PER_BEAT; s++) begin
        word = dac_ddata[(c*`SAMPLES_PER_BEAT+s)*`DMA_BITS +: `DMA_BITS];
        if (`PAD_TO_MSB == 1)
          beat_in[c][s] = word[`SAMPLE_BITS-1:0];
        else
          beat_in[c][s] = word[`DMA_BITS-1 -: `SAMPLE_BITS];
      end
    end
  end

  always_ff @(posedge link_clk) begin
    if (rst) begin
      dma_beat  <= '0;
      dunf_flag <= 1'b0;
    end else begin
      // underflow only counts on beats actually consumed
      dunf_flag <= dac_dunf & link_ready;
      if (link_ready)
        dma_beat <= beat_in;
    end
  end

  a_beat_known: assert property (@(posedge link_clk) disable iff (rst)
    !$isunknown(dma_beat));

endmodule

//--- source/tpl_dac_regmap.sv
/*
 * Transport-layer DAC register map
 * strobe bus decode, channel enables, per-channel source config,
 * sticky DMA underflow status and registered read data
 */

`include "tpl_dac_params.svh"

module tpl_dac_regmap (
  input  logic                                        link_clk,
  input  logic                                        rst,
  input  logic                                        reg_wr,
  input  logic                                        reg_rd,
  input  logic [7:0]                                  reg_addr,
  input  logic [31:0]                                 reg_wdata,
  output logic [31:0]                                 reg_rdata,
  input  logic                                        dunf_flag,
  output logic [`NUM_CHANNELS-1:0]                    enable,
  output tpl_dac_pkg::chan_cfg_t [`NUM_CHANNELS-1:0]  cfg
);

  import tpl_dac_pkg::*;

  logic        dunf_sticky;
  logic [31:0] rd_mux;

  // **************************************************
  // write side
  // **************************************************

  always_ff @(posedge link_clk) begin
    if (rst) begin
      enable      <= '0;
      dunf_sticky <= 1'b0;
      for (int c = 0; c < `NUM_CHANNELS; c++) begin
        cfg[c].src_sel   <= SRC_DMA;
        cfg[c].pattern   <= '0;
        cfg[c].ramp_step <= '0;
      end
    end else begin
      if (reg_wr && reg_addr == `REG_CTRL)
        enable <= reg_wdata[`NUM_CHANNELS-1:0];
      for (int c = 0; c < `NUM_CHANNELS; c++) begin
        if (reg_wr && reg_addr == 8'(`REG_CH_SEL + c))
          cfg[c].src_sel <= src_sel_e'(reg_wdata[1:0]);
        if (reg_wr && reg_addr == 8'(`REG_CH_PAT + c))
          cfg[c].pattern <= reg_wdata[`SAMPLE_BITS-1:0];
        if (reg_wr && reg_addr == 8'(`REG_CH_STEP + c))
          cfg[c].ramp_step <= reg_wdata[`SAMPLE_BITS-1:0];
      end
      // a new underflow wins over a clear in the same cycle
      if (dunf_flag)
        dunf_sticky <= 1'b1;
      else if (reg_wr && reg_addr == `REG_STATUS && reg_wdata[0])
        dunf_sticky <= 1'b0;
    end
  end

  // **************************************************
  // read side
  // **************************************************

  always_comb begin
    case (reg_addr)
      `REG_ID:     rd_mux = `CORE_ID;
      `REG_CTRL:   rd_mux = 32'(enable);
      `REG_STATUS: rd_mux = {31'd0, dunf_sticky};
      default:     rd_mux = '0;
    endcase
    for (int c = 0; c < `NUM_CHANNELS; c++) begin
      if (reg_addr == 8'(`REG_CH_SEL + c))
        rd_mux = 32'(cfg[c].src_sel);
      if (reg_addr == 8'(`REG_CH_PAT + c))
        rd_mux = 32'(cfg[c].pattern);
      if (reg_addr == 8'(`REG_CH_STEP + c))
        rd_mux = 32'(cfg[c].ramp_step);
    end
  end

  // held until the next read strobe
  always_ff @(posedge link_clk) begin
    if (rst)
      reg_rdata <= '0;
    else if (reg_rd)
      reg_rdata <= rd_mux;
  end

  a_no_rd_wr: assert property (@(posedge link_clk) disable iff (rst)
    !(reg_wr && reg_rd));

endmodule

//--- source/channel_source_sel.sv
/*
 * Channel source select
 * per channel picks DMA, constant pattern, ramp or zero,
 * masks disabled channels and registers the result
 */

`include "tpl_dac_params.svh"

module channel_source_sel (
  input  logic                                        link_clk,
  input  logic                                        rst,
  input  logic                                        link_ready,
  input  logic [`NUM_CHANNELS-1:0]                    enable,
  input  tpl_dac_pkg::chan_cfg_t [`NUM_CHANNELS-1:0]  cfg,
  input  tpl_dac_pkg::chan_beat_t [`NUM_CHANNELS-1:0] dma_beat,
  output tpl_dac_pkg::chan_beat_t [`NUM_CHANNELS-1:0] src_beat
);

  import tpl_dac_pkg::*;

  sample_t    [`NUM_CHANNELS-1:0] ramp_acc;
  chan_beat_t [`NUM_CHANNELS-1:0] beat_next;

  for (genvar c = 0; c < `NUM_CHANNELS; c++) begin : g_chan

    // **************************************************
    // ramp generator
    // **************************************************

    // two samples per beat, so the accumulator moves by twice the step
    always_ff @(posedge link_clk) begin
      if (rst) begin
        ramp_acc[c] <= '0;
      end else if (link_ready) begin
        if (cfg[c].src_sel != SRC_RAMP)
          ramp_acc[c] <= '0;
        else if (enable[c])
          ramp_acc[c] <= sample_t'(ramp_acc[c] + (cfg[c].ramp_step << 1));
      end
    end

    // **************************************************
    // source mux
    // **************************************************

    always_comb begin
      beat_next[c] = '0;
      if (enable[c]) begin
        case (cfg[c].src_sel)
          SRC_DMA:     beat_next[c] = dma_beat[c];
          SRC_PATTERN: beat_next[c] = {`SAMPLES_PER_BEAT{cfg[c].pattern}};
          SRC_RAMP: begin
            beat_next[c][0] = ramp_acc[c];
            beat_next[c][1] = sample_t'(ramp_acc[c] + cfg[c].ramp_step);
          end
          default:     beat_next[c] = '0;
        endcase
      end
    end

    always_ff @(posedge link_clk) begin
      if (rst)
        src_beat[c] <= '0;
      else if (link_ready)
        src_beat[c] <= beat_next[c];
    end

    // every 2-bit code names a source, so only an unknown select is illegal
    a_sel_legal: assert property (@(posedge link_clk) disable iff (rst)
      !$isunknown(cfg[c].src_sel));

  end

endmodule

//--- source/link_framer.sv
/*
 * Link framer
 * places each sample MSB-aligned into a slot, splits slots into
 * lane octets high byte first and registers the link word
 */

`include "tpl_dac_params.svh"

module link_framer (
  input  logic                                        link_clk,
  input  logic                                        rst,
  input  logic                                        link_ready,
  input  tpl_dac_pkg::chan_beat_t [`NUM_CHANNELS-1:0] src_beat,
  output logic [`LINK_BITS-1:0]                       link_data,
  output logic                                        link_valid
);

  import tpl_dac_pkg::*;

  localparam int LANE_BITS = `OCTETS_PER_BEAT * 8;

  logic [`LINK_BITS-1:0] frame_next;

  // channel l rides on lane l
  always_comb begin
    slot_t slot;
    frame_next = '0;
    for (int l = 0; l < `NUM_LANES; l++) begin
      for (int s = 0; s < `SAMPLES_PER_BEAT; s++) begin
        // sample in the MSBs, zero tail bits below
        slot = slot_t'(src_beat[l][s]) << (`SLOT_BITS - `SAMPLE_BITS);
        frame_next[l*LANE_BITS + (2*s)*8 +: 8]   = slot[15:8];
        frame_next[l*LANE_BITS + (2*s+1)*8 +: 8] = slot[7:0];
      end
    end
  end

  always_ff @(posedge link_clk) begin
    if (rst)
      link_data <= '0;
    else if (link_ready)
      link_data <= frame_next;
  end

  // valid from the first edge out of reset on
  always_ff @(posedge link_clk) begin
    if (rst)
      link_valid <= 1'b0;
    else
      link_valid <= 1'b1;
  end

  // the upstream stage must hold its beat through a gap as well
  a_hold_data: assert property (@(posedge link_clk) disable iff (rst)
    !link_ready |=> $stable(link_data) && $stable(src_beat));

endmodule

//--- source/tpl_dac_top.sv
/*
 * JESD204 transport-layer DAC, single clock domain
 * DMA unpack, source select and lane framing behind a strobe register bus
 */

`include "tpl_dac_params.svh"

module tpl_dac_top (
  input  logic                                                 link_clk,
  input  logic                                                 rst,
  output logic [`LINK_BITS-1:0]                                link_data,
  output logic                                                 link_valid,
  input  logic                                                 link_ready,
  output logic [`NUM_CHANNELS-1:0]                             enable,
  output logic [`NUM_CHANNELS-1:0]                             dac_valid,
  input  logic [`NUM_CHANNELS*`SAMPLES_PER_BEAT*`DMA_BITS-1:0] dac_ddata,
  input  logic                                                 dac_dunf,
  input  logic                                                 reg_wr,
  input  logic                                                 reg_rd,
  input  logic [7:0]                                           reg_addr,
  input  logic [31:0]                                          reg_wdata,
  output logic [31:0]                                          reg_rdata
);

  import tpl_dac_pkg::*;

  chan_cfg_t  [`NUM_CHANNELS-1:0] cfg;
  chan_beat_t [`NUM_CHANNELS-1:0] dma_beat;
  chan_beat_t [`NUM_CHANNELS-1:0] src_beat;
  logic                           dunf_flag;

  // DMA words are consumed on the same edge the link takes a beat
  assign dac_valid = enable & {`NUM_CHANNELS{link_ready}};

  dma_sample_unpack i_unpack (
    .link_clk   (link_clk),
    .rst        (rst),
    .link_ready (link_ready),
    .dac_ddata  (dac_ddata),
    .dac_dunf   (dac_dunf),
    .dma_beat   (dma_beat),
    .dunf_flag  (dunf_flag)
  );

  tpl_dac_regmap i_regmap (
    .link_clk  (link_clk),
    .rst       (rst),
    .reg_wr    (reg_wr),
    .reg_rd    (reg_rd),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .reg_rdata (reg_rdata),
    .dunf_flag (dunf_flag),
    .enable    (enable),
    .cfg       (cfg)
  );

  channel_source_sel i_source_sel (
    .link_clk   (link_clk),
    .rst        (rst),
    .link_ready (link_ready),
    .enable     (enable),
    .cfg        (cfg),
    .dma_beat   (dma_beat),
    .src_beat   (src_beat)
  );

  link_framer i_framer (
    .link_clk   (link_clk),
    .rst        (rst),
    .link_ready (link_ready),
    .src_beat   (src_beat),
    .link_data  (link_data),
    .link_valid (link_valid)
  );

endmodule

//--- dv/tb_tpl_dac.sv
/*
 * Testbench for the transport-layer DAC
 * random DMA traffic, pattern, zero and ramp sources, link back-pressure
 * and underflow status, checked against a pipeline reference model
 */

`include "tpl_dac_params.svh"

module tb_tpl_dac;

  timeunit 1ns;
  timeprecision 100ps;

  import tpl_dac_pkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int LANE_BITS  = `OCTETS_PER_BEAT * 8;
  localparam int DMA_BEATS  = 64;
  localparam int PAT_BEATS  = 16;
  localparam int RAMP_BEATS = 40;
  localparam int BP_BEATS   = 200;
  // reset, idle gaps and register accesses
  localparam int MISC_BEATS = 96;
  localparam int TEST_BEATS = DMA_BEATS + 2 * PAT_BEATS + RAMP_BEATS + BP_BEATS + MISC_BEATS;

  typedef struct packed {
    logic [`LINK_BITS-1:0] data;
    logic [`LINK_BITS-1:0] mask;
  } exp_word_t;

  logic                                                 link_clk;
  logic                                                 rst;
  logic [`LINK_BITS-1:0]                                link_data;
  logic                                                 link_valid;
  logic                                                 link_ready;
  logic [`NUM_CHANNELS-1:0]                             enable;
  logic [`NUM_CHANNELS-1:0]                             dac_valid;
  logic [`NUM_CHANNELS*`SAMPLES_PER_BEAT*`DMA_BITS-1:0] dac_ddata;
  logic                                                 dac_dunf;
  logic                                                 reg_wr;
  logic                                                 reg_rd;
  logic [7:0]                                           reg_addr;
  logic [31:0]                                          reg_wdata;
  logic [31:0]                                          reg_rdata;

  // shadow of the register map and expected link stream
  logic [`NUM_CHANNELS-1:0] m_en;
  src_sel_e                 m_sel [`NUM_CHANNELS];
  sample_t                  m_pat [`NUM_CHANNELS];
  sample_t                  m_step [`NUM_CHANNELS];
  int                       ramp_beats [`NUM_CHANNELS];
  sample_t                  last_s1 [`NUM_CHANNELS];
  exp_word_t                exp_q [$];
  exp_word_t                exp_word;
  logic                     exp_vld;
  logic                     exp_valid;
  logic                     started = 1'b0;
  logic [31:0]              rng_state = 32'h8612816d;

  tpl_dac_top dut0 (
    .link_clk   (link_clk),
    .rst        (rst),
    .link_data  (link_data),
    .link_valid (link_valid),
    .link_ready (link_ready),
    .enable     (enable),
    .dac_valid  (dac_valid),
    .dac_ddata  (dac_ddata),
    .dac_dunf   (dac_dunf),
    .reg_wr     (reg_wr),
    .reg_rd     (reg_rd),
    .reg_addr   (reg_addr),
    .reg_wdata  (reg_wdata),
    .reg_rdata  (reg_rdata)
  );

  initial begin
    link_clk = 1'b0;
    forever #(CLK_PERIOD / 2) link_clk = ~link_clk;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  function automatic logic [31:0] next_random(input logic [31:0] x);
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  // **************************************************
  // reference model
  // **************************************************

  // sample s of lane l, octet 2s is the slot's high byte
  function automatic sample_t lane_sample(input logic [`LINK_BITS-1:0] data,
                                          input int lane, input int s);
    slot_t slot;
    slot = {data[lane*LANE_BITS + 2*s*8 +: 8], data[lane*LANE_BITS + (2*s+1)*8 +: 8]};
    return slot[`SLOT_BITS-1 -: `SAMPLE_BITS];
  endfunction

  task automatic apply_write(input logic [7:0] addr, input logic [31:0] data);
    if (addr == `REG_CTRL)
      m_en = data[`NUM_CHANNELS-1:0];
    for (int c = 0; c < `NUM_CHANNELS; c++) begin
      if (addr == `REG_CH_SEL + c)
        m_sel[c] = src_sel_e'(data[1:0]);
      if (addr == `REG_CH_PAT + c)
        m_pat[c] = data[`SAMPLE_BITS-1:0];
      if (addr == `REG_CH_STEP + c)
        m_step[c] = data[`SAMPLE_BITS-1:0];
    end
  endtask

  // ramp lanes are masked out here and checked by the step assertion
  function automatic exp_word_t expect_beat(
      input logic [`NUM_CHANNELS*`SAMPLES_PER_BEAT*`DMA_BITS-1:0] ddata);
    exp_word_t e;
    dma_word_t word;
    sample_t   smp;
    slot_t     slot;
    e.data = '0;
    e.mask = '1;
    for (int c = 0; c < `NUM_CHANNELS; c++) begin
      for (int s = 0; s < `SAMPLES_PER_BEAT; s++) begin
        word = ddata[(c*`SAMPLES_PER_BEAT+s)*`DMA_BITS +: `DMA_BITS];
        smp = (`PAD_TO_MSB == 1) ? word[`SAMPLE_BITS-1:0] : word[`DMA_BITS-1 -: `SAMPLE_BITS];
        if (!m_en[c] || m_sel[c] == SRC_ZERO)
          smp = '0;
        else if (m_sel[c] == SRC_PATTERN)
          smp = m_pat[c];
        else if (m_sel[c] == SRC_RAMP)
          e.mask[c*LANE_BITS +: LANE_BITS] = '0;
        slot = {smp, {(`SLOT_BITS-`SAMPLE_BITS){1'b0}}};
        e.data[c*LANE_BITS + 2*s*8 +: 8]     = slot[`SLOT_BITS-1 -: 8];
        e.data[c*LANE_BITS + (2*s+1)*8 +: 8] = slot[7:0];
      end
    end
    return e;
  endfunction

  // a beat taken at ready edge k is on link_data after the second ready edge
  // that follows, so it is compared on the third
  always @(posedge link_clk) begin
    started   <= 1'b1;
    exp_valid <= !rst;
    if (rst) begin
      m_en = '0;
      for (int c = 0; c < `NUM_CHANNELS; c++) begin
        m_sel[c]      = SRC_DMA;
        m_pat[c]      = '0;
        m_step[c]     = '0;
        ramp_beats[c] = 0;
        last_s1[c]    = '0;
      end
      exp_q.delete();
      exp_vld <= 1'b0;
    end else begin
      if (reg_wr)
        apply_write(reg_addr, reg_wdata);
      if (link_ready) begin
        exp_q.push_back(expect_beat(dac_ddata));
        if (exp_q.size() > 3)
          void'(exp_q.pop_front());
        for (int c = 0; c < `NUM_CHANNELS; c++) begin
          last_s1[c] = lane_sample(link_data, c, 1);
          if (m_en[c] && m_sel[c] == SRC_RAMP) begin
            if (ramp_beats[c] < 8)
              ramp_beats[c]++;
          end else begin
            ramp_beats[c] = 0;
          end
        end
      end
      exp_vld <= (exp_q.size() == 3);
      if (exp_q.size() == 3)
        exp_word <= exp_q[0];
    end
  end

  // **************************************************
  // checks
  // **************************************************

  a_link_valid: assert property (@(posedge link_clk) started |-> link_valid == exp_valid)
    else report_failure($sformatf("Error: link_valid = %h, expected %h",
      $sampled(link_valid), $sampled(exp_valid)));

  a_link_word: assert property (@(posedge link_clk) disable iff (rst)
    exp_vld |-> ((link_data ^ exp_word.data) & exp_word.mask) == '0)
    else report_failure($sformatf("Error: link_data = %h, expected %h (mask %h)",
      $sampled(link_data), $sampled(exp_word.data), $sampled(exp_word.mask)));

  a_enable: assert property (@(posedge link_clk) disable iff (rst) enable == m_en)
    else report_failure($sformatf("Error: enable = %h, expected %h",
      $sampled(enable), $sampled(m_en)));

  a_dac_valid: assert property (@(posedge link_clk) disable iff (rst)
    dac_valid == (m_en & {`NUM_CHANNELS{link_ready}}))
    else report_failure($sformatf("Error: dac_valid = %h, expected %h",
      $sampled(dac_valid), $sampled(m_en & {`NUM_CHANNELS{link_ready}})));

  a_link_hold: assert property (@(posedge link_clk) disable iff (rst)
    !link_ready |=> $stable(link_data))
    else report_failure($sformatf("Error: link_data = %h, changed from %h during a ready gap",
      $sampled(link_data), $past(link_data)));

  // consecutive ramp samples, also across the beat boundary
  for (genvar c = 0; c < `NUM_CHANNELS; c++) begin : g_ramp
    a_ramp_step: assert property (@(posedge link_clk) disable iff (rst)
      ramp_beats[c] >= 5 |->
        sample_t'(lane_sample(link_data, c, 1) - lane_sample(link_data, c, 0)) == m_step[c] &&
        sample_t'(lane_sample(link_data, c, 0) - last_s1[c]) == m_step[c])
      else report_failure($sformatf("Error: link_data lane %0d ramp %h %h after %h, step %h",
        c, lane_sample($sampled(link_data), c, 0), lane_sample($sampled(link_data), c, 1),
        $sampled(last_s1[c]), $sampled(m_step[c])));
  end

  // **************************************************
  // stimulus
  // **************************************************

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge link_clk);
  endtask

  task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
    @(negedge link_clk);
    reg_wr    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge link_clk);
    reg_wr = 1'b0;
  endtask

  task automatic reg_read(input logic [7:0] addr, output logic [31:0] data);
    @(negedge link_clk);
    reg_rd   = 1'b1;
    reg_addr = addr;
    @(negedge link_clk);
    reg_rd = 1'b0;
    data   = reg_rdata;
  endtask

  task automatic check_reg(input logic [7:0] addr, input logic [31:0] expected);
    logic [31:0] data;
    reg_read(addr, data);
    a_reg_value: assert (data === expected)
      else report_failure($sformatf("Error: reg_rdata at %h = %h, expected %h",
        addr, data, expected));
  endtask

  // new DMA words every cycle, optional random ready gaps
  task automatic run_beats(input int n, input bit gaps);
    for (int i = 0; i < n; i++) begin
      @(negedge link_clk);
      rng_state = next_random(rng_state);
      dac_ddata[31:0] = rng_state;
      rng_state = next_random(rng_state);
      dac_ddata[63:32] = rng_state;
      rng_state = next_random(rng_state);
      link_ready = gaps ? (rng_state[1:0] != 2'b00) : 1'b1;
    end
    @(negedge link_clk);
    link_ready = 1'b1;
  endtask

  initial begin
    #((TEST_BEATS + 200) * CLK_PERIOD);
    report_failure("watchdog expired before the tests finished");
  end

  initial begin
    rst        = 1'b1;
    link_ready = 1'b1;
    dac_ddata  = '0;
    dac_dunf   = 1'b0;
    reg_wr     = 1'b0;
    reg_rd     = 1'b0;
    reg_addr   = '0;
    reg_wdata  = '0;
    repeat (2) @(posedge link_clk);
    @(negedge link_clk);
    rst = 1'b0;

    // reset state and ID
    wait_cycles(4);
    check_reg(`REG_ID, `CORE_ID);

    // DMA path
    reg_write(`REG_CTRL, 32'h3);
    run_beats(DMA_BEATS, 1'b0);

    // pattern, zero and a disabled channel
    reg_write(`REG_CH_PAT + 0, 32'hA5C);
    reg_write(`REG_CH_SEL + 0, SRC_PATTERN);
    reg_write(`REG_CH_SEL + 1, SRC_ZERO);
    run_beats(PAT_BEATS, 1'b0);
    reg_write(`REG_CTRL, 32'h1);
    reg_write(`REG_CH_SEL + 1, SRC_DMA);
    run_beats(PAT_BEATS, 1'b0);
    reg_write(`REG_CTRL, 32'h3);
    reg_write(`REG_CH_SEL + 0, SRC_DMA);

    // ramp, channel 1 wraps downwards
    reg_write(`REG_CH_STEP + 0, 32'h123);
    reg_write(`REG_CH_STEP + 1, 32'hFFF);
    reg_write(`REG_CH_SEL + 0, SRC_RAMP);
    reg_write(`REG_CH_SEL + 1, SRC_RAMP);
    run_beats(RAMP_BEATS, 1'b0);
    reg_write(`REG_CH_SEL + 0, SRC_DMA);
    reg_write(`REG_CH_SEL + 1, SRC_DMA);

    // back-pressure
    run_beats(BP_BEATS, 1'b1);

    // underflow, sticky until cleared
    @(negedge link_clk);
    dac_dunf = 1'b1;
    @(negedge link_clk);
    dac_dunf = 1'b0;
    check_reg(`REG_STATUS, 32'h1);
    reg_write(`REG_STATUS, 32'h1);
    wait_cycles(4);
    check_reg(`REG_STATUS, 32'h0);
    wait_cycles(8);
    check_reg(`REG_STATUS, 32'h0);

    $display("TESTS PASSED");
    $finish;
  end

endmodule

//--- sources.f
+incdir+source
source/tpl_dac_pkg.sv
source/dma_sample_unpack.sv
source/tpl_dac_regmap.sv
source/channel_source_sel.sv
source/link_framer.sv
source/tpl_dac_top.sv
dv/tb_tpl_dac.sv

//--- Bender.yml
package:
  name: tpl_dac

sources:
  - include_dirs:
      - source
    files:
      - source/tpl_dac_pkg.sv
      - source/dma_sample_unpack.sv
      - source/tpl_dac_regmap.sv
      - source/channel_source_sel.sv
      - source/link_framer.sv
      - source/tpl_dac_top.sv

  - target: simulation
    include_dirs:
      - source
    files:
      - dv/tb_tpl_dac.sv
